// ==== coreControl.sv ====
`include "cpu_macros.svh"

module coreControl (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               halt,
    input  logic               done,
    input  cpuPkg::operandKind kind,
    input  logic               storing,
    input  logic               derefRhs,
    input  logic               branch,
    input  logic [4:0]         vector,
    input  logic [31:0]        result,
    input  logic [31:0]        valZ,
    input  logic [31:0]        iData,
    input  logic [31:0]        dRdata,
    output logic               start,
    output logic               regWrite,
    output logic               dStrobe,
    output logic               dWrite,
    output logic [31:0]        insn,
    output logic [31:0]        P,
    output logic [31:0]        writeData,
    output logic [31:0]        iAddr,
    output logic [31:0]        dAddr,
    output logic [31:0]        dWdata
);
    import cpuPkg::*;

    coreState    state;
    coreState    nextState;
    // ALU result, vector address or return address depending on the state
    logic [31:0] rhs;
    logic [31:0] loadData;
    logic [31:0] vecTarget;
    logic        loading;

    assign loading = derefRhs && !storing;

    always_comb begin
        nextState = state;
        case (state)
            sIdle:      nextState = halt ? sIdle : sNextPc;
            sExec: begin
                if (halt) begin
                    nextState = sIdle;
                end else if (kind == kindThrow) begin
                    nextState = sThrow;
                end else begin
                    nextState = sWaitExec;
                end
            end
            sWaitExec:  nextState = done ? sMem : sWaitExec;
            sMem:       nextState = sCommit;
            sCommit:    nextState = sNextPc;
            sNextPc:    nextState = sFetch;
            sFetch:     nextState = sExec;
            sThrow:     nextState = sVecRead;
            sVecRead:   nextState = sSaveRet;
            sSaveRet:   nextState = sTrapStore;
            sTrapStore: nextState = sNextPc;
            default:    nextState = sIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            sIdle:      iAddr <= `RESET_VECTOR;
            sWaitExec:  rhs <= result;
            sMem:       loadData <= dRdata;
            // A jump takes the same value that would have gone to Z
            sCommit:    iAddr <= branch ? writeData : P;
            sNextPc:    P <= iAddr + 32'd1;
            sFetch:     insn <= iData;
            sThrow:     rhs <= `VECTOR_BASE | {27'd0, vector};
            sVecRead:   vecTarget <= dRdata;
            sSaveRet:   rhs <= iAddr;
            sTrapStore: iAddr <= vecTarget;
            default:    ;
        endcase
    end

    assign start    = (state == sExec) && !halt && (kind != kindThrow);
    assign regWrite = (state == sCommit) && !storing;
    assign dStrobe  = ((state == sMem) && (loading || storing))
                   || (state == sVecRead) || (state == sTrapStore);
    assign dWrite   = ((state == sMem) && storing) || (state == sTrapStore);

    assign writeData = derefRhs ? loadData : rhs;

    // Dereference uses the ALU result as address, otherwise Z is the address
    always_comb begin
        dAddr  = derefRhs ? rhs : valZ;
        dWdata = derefRhs ? valZ : rhs;
        if (state == sVecRead) begin
            dAddr = rhs;
        end else if (state == sTrapStore) begin
            dAddr  = `TRAP_SLOT;
            dWdata = rhs;
        end
    end

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    // Instruction-cycle states of the controller
    typedef enum logic [3:0] {
        sIdle      = 4'd0,
        sExec      = 4'd1,
        sWaitExec  = 4'd2,
        sMem       = 4'd3,
        sCommit    = 4'd4,
        sNextPc    = 4'd5,
        sFetch     = 4'd6,
        sThrow     = 4'd7,
        sVecRead   = 4'd8,
        sSaveRet   = 4'd9,
        sTrapStore = 4'd10
    } coreState;

    // ALU opcodes with encoding 4 left unassigned
    // Comparisons return all-ones for true
    typedef enum logic [3:0] {
        opOr   = 4'd0,
        opAnd  = 4'd1,
        opAdd  = 4'd2,
        opMul  = 4'd3,
        opShl  = 4'd5,
        opLt   = 4'd6,
        opEq   = 4'd7,
        opGe   = 4'd8,
        opAndn = 4'd9,
        opXor  = 4'd10,
        opSub  = 4'd11,
        opXnor = 4'd12,
        opShr  = 4'd13,
        opNe   = 4'd14,
        opSar  = 4'd15
    } aluOp;

    // Order of X, Y and immediate on the ALU inputs A, B and C
    typedef enum logic [1:0] {
        kindXYI   = 2'd0,
        kindXIY   = 2'd1,
        kindIXY   = 2'd2,
        kindThrow = 2'd3
    } operandKind;

endpackage

// ==== cpuTop.sv ====
module cpuTop (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        halt,
    input  logic [31:0] iData,
    input  logic [31:0] dRdata,
    output logic [31:0] iAddr,
    output logic [31:0] dAddr,
    output logic [31:0] dWdata,
    output logic        dStrobe,
    output logic        dWrite
);
    import cpuPkg::*;

    logic [3:0]  idxX;
    logic [3:0]  idxY;
    logic [3:0]  idxZ;
    aluOp        op;
    operandKind  kind;
    logic        storing;
    logic        derefRhs;
    logic        branch;
    logic [4:0]  vector;
    logic [31:0] A;
    logic [31:0] B;
    logic [31:0] C;
    logic [31:0] valX;
    logic [31:0] valY;
    logic [31:0] valZ;
    logic [31:0] insn;
    logic [31:0] P;
    logic [31:0] writeData;
    logic [31:0] result;
    logic        regWrite;
    logic        start;
    logic        done;

    coreControl control_i (
        .clk(clk), .reset_n(reset_n), .halt(halt), .done(done),
        .kind(kind), .storing(storing), .derefRhs(derefRhs), .branch(branch),
        .vector(vector), .result(result), .valZ(valZ), .iData(iData),
        .dRdata(dRdata), .start(start), .regWrite(regWrite), .dStrobe(dStrobe),
        .dWrite(dWrite), .insn(insn), .P(P), .writeData(writeData),
        .iAddr(iAddr), .dAddr(dAddr), .dWdata(dWdata)
    );

    insnDecode decode_i (
        .insn(insn), .valX(valX), .valY(valY),
        .idxX(idxX), .idxY(idxY), .idxZ(idxZ), .op(op), .kind(kind),
        .storing(storing), .derefRhs(derefRhs), .branch(branch),
        .vector(vector), .A(A), .B(B), .C(C)
    );

    regFile regs_i (
        .clk(clk), .regWrite(regWrite), .idxX(idxX), .idxY(idxY), .idxZ(idxZ),
        .writeData(writeData), .P(P), .valX(valX), .valY(valY), .valZ(valZ)
    );

    stepTimer timer_i (
        .clk(clk), .reset_n(reset_n), .start(start), .done(done)
    );

    execUnit exec_i (
        .clk(clk), .start(start), .op(op), .A(A), .B(B), .C(C), .result(result)
    );

endmodule

// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// All addresses count 32-bit words

// First instruction after reset or halt release
`define RESET_VECTOR 32'h0000_0010

// Throw vectors sit here with the low five bits taken from the instruction
`define VECTOR_BASE 32'h0000_0020

// Return address of the last throw is stored here
`define TRAP_SLOT 32'h0000_00F0

// Cycles from the ALU start pulse to a valid result
`define ALU_LATENCY 3

`endif

// ==== execUnit.sv ====
`include "cpu_macros.svh"

module execUnit (
    input  logic         clk,
    input  logic         start,
    input  cpuPkg::aluOp op,
    input  logic [31:0]  A,
    input  logic [31:0]  B,
    input  logic [31:0]  C,
    output logic [31:0]  result
);
    import cpuPkg::*;

    // One valid bit for each stage behind the operand capture
    logic [`ALU_LATENCY-2:0] stageValid;
    aluOp        opReg;
    logic [31:0] aReg;
    logic [31:0] bReg;
    logic [31:0] cReg;
    logic [31:0] opValue;
    logic [31:0] opOut;
    logic [31:0] cStage;

    always_ff @(posedge clk) begin
        stageValid <= {stageValid[`ALU_LATENCY-3:0], start};
    end

    always_ff @(posedge clk) begin
        if (start) begin
            opReg <= op;
            aReg  <= A;
            bReg  <= B;
            cReg  <= C;
        end
    end

    always_comb begin
        case (opReg)
            opOr:    opValue = aReg | bReg;
            opAnd:   opValue = aReg & bReg;
            opAdd:   opValue = aReg + bReg;
            opMul:   opValue = aReg * bReg;
            opShl:   opValue = aReg << bReg;
            opLt:    opValue = {32{$signed(aReg) < $signed(bReg)}};
            opEq:    opValue = {32{aReg == bReg}};
            opGe:    opValue = {32{$signed(aReg) >= $signed(bReg)}};
            opAndn:  opValue = aReg & ~bReg;
            opXor:   opValue = aReg ^ bReg;
            opSub:   opValue = aReg - bReg;
            opXnor:  opValue = aReg ~^ bReg;
            opShr:   opValue = aReg >> bReg;
            opNe:    opValue = {32{aReg != bReg}};
            opSar:   opValue = $signed(aReg) >>> bReg;
            default: opValue = '0;
        endcase
    end

    // Operation in the first stage, the add of C in the second
    always_ff @(posedge clk) begin
        if (stageValid[0]) begin
            opOut  <= opValue;
            cStage <= cReg;
        end
        if (stageValid[`ALU_LATENCY-2]) begin
            result <= opOut + cStage;
        end
    end

endmodule

// ==== insnDecode.sv ====
module insnDecode (
    input  logic [31:0]        insn,
    input  logic [31:0]        valX,
    input  logic [31:0]        valY,
    output logic [3:0]         idxX,
    output logic [3:0]         idxY,
    output logic [3:0]         idxZ,
    output cpuPkg::aluOp       op,
    output cpuPkg::operandKind kind,
    output logic               storing,
    output logic               derefRhs,
    output logic               branch,
    output logic [4:0]         vector,
    output logic [31:0]        A,
    output logic [31:0]        B,
    output logic [31:0]        C
);
    import cpuPkg::*;

    logic [31:0] imm;

    // kind | store | deref | Z | X | Y | op | imm12
    assign kind     = operandKind'(insn[31:30]);
    assign storing  = insn[29];
    assign derefRhs = insn[28];
    assign idxZ     = insn[27:24];
    assign idxX     = insn[23:20];
    assign idxY     = insn[19:16];
    assign op       = aluOp'(insn[15:12]);
    assign imm      = {{20{insn[11]}}, insn[11:0]};

    // A throw reuses the low immediate bits as its vector number
    assign vector = insn[4:0];

    assign branch = (idxZ == 4'd15) && !storing;

    always_comb begin
        case (kind)
            kindXIY: begin
                A = valX;
                B = imm;
                C = valY;
            end
            kindIXY: begin
                A = imm;
                B = valX;
                C = valY;
            end
            default: begin
                // Throws never start the ALU
                A = valX;
                B = valY;
                C = imm;
            end
        endcase
    end

endmodule

// ==== regFile.sv ====
module regFile (
    input  logic        clk,
    input  logic        regWrite,
    input  logic [3:0]  idxX,
    input  logic [3:0]  idxY,
    input  logic [3:0]  idxZ,
    input  logic [31:0] writeData,
    input  logic [31:0] P,
    output logic [31:0] valX,
    output logic [31:0] valY,
    output logic [31:0] valZ
);

    // Only registers 1 to 14 have storage
    logic [31:0] regs [1:14];

    function automatic logic [31:0] readPort(input logic [3:0] idx);
        logic [31:0] value;
        if (idx == 4'd15) begin
            value = P;
        end else if (idx == 4'd0) begin
            value = '0;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb begin
        valX = readPort(idxX);
        valY = readPort(idxY);
        valZ = readPort(idxZ);
    end

    // Writes to r0 and to P are dropped here
    always_ff @(posedge clk) begin
        if (regWrite && idxZ != 4'd0 && idxZ != 4'd15) begin
            regs[idxZ] <= writeData;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing -Wno-fatal --top-module tbTop -f vlog.f -o simv
./obj_dir/simv > sim.log
cat sim.log
grep -q "ALL TESTS PASSED" sim.log

// ==== stepTimer.sv ====
`include "cpu_macros.svh"

module stepTimer (
    input  logic clk,
    input  logic reset_n,
    input  logic start,
    output logic done
);

    localparam int CountW = $clog2(`ALU_LATENCY + 1);

    logic [CountW-1:0] count;

    // A start in the middle of a count simply reloads it
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            count <= '0;
        end else if (start) begin
            count <= CountW'(`ALU_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // High for the last counted cycle only
    assign done = (count == CountW'(1));

endmodule

// ==== tbChecker.sv ====
module tbChecker #(
    parameter int TimeoutCycles = 1000
) (
    input  logic        clk,
    input  logic        dStrobe,
    input  logic        dWrite,
    input  logic [31:0] dAddr,
    input  logic [31:0] dWdata,
    output logic        timedOut
);

    logic [31:0] expAddrQ [$];
    logic [31:0] expDataQ [$];
    logic [31:0] poisonAddr;
    string       testLabel;
    int          testIndex;
    int          testErrors;
    int          passCount;
    int          failCount;
    int          doneCount;
    int          cycles;
    logic        active;

    initial begin
        timedOut = 1'b0;
        active = 1'b0;
        poisonAddr = 32'hffff_ffff;
        testIndex = 0;
        testErrors = 0;
        passCount = 0;
        failCount = 0;
        doneCount = 0;
        cycles = 0;
    end

    task automatic beginTest(input int index, input string label, input logic [31:0] poison);
        testIndex = index;
        testLabel = label;
        poisonAddr = poison;
        testErrors = 0;
        expAddrQ.delete();
        expDataQ.delete();
        active = 1'b1;
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddrQ.push_back(addr);
        expDataQ.push_back(data);
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            passCount++;
            $display("Test %0d (%s) passed", testIndex, testLabel);
        end else begin
            failCount++;
            $display("Test %0d (%s) failed with %0d errors", testIndex, testLabel, testErrors);
        end
        active = 1'b0;
        doneCount++;
    endtask

    task automatic checkStore();
        logic [31:0] ea;
        logic [31:0] ed;
        if (dAddr == poisonAddr) begin
            $display("Test %0d: a store reached the poison address %h", testIndex, dAddr);
            testErrors++;
        end else if (expAddrQ.size() == 0) begin
            $display("Test %0d: unexpected store of %h at address %h", testIndex, dWdata, dAddr);
            testErrors++;
        end else begin
            ea = expAddrQ.pop_front();
            ed = expDataQ.pop_front();
            if (dAddr !== ea) begin
                $display("** Error: dAddr expected %h, actual %h", ea, dAddr);
                testErrors++;
            end
            if (dWdata !== ed) begin
                $display("** Error: dWdata expected %h, actual %h", ed, dWdata);
                testErrors++;
            end
            if (expAddrQ.size() == 0) begin
                finishTest();
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TimeoutCycles) begin
            timedOut = 1'b1;
        end
        if (active && dStrobe && dWrite) begin
            checkStore();
        end
    end

endmodule

// ==== tbTop.sv ====
`include "cpu_macros.svh"

module tbTop;
    import cpuPkg::*;

    localparam int RowCount = 24;
    localparam int ProgLen = 6;
    localparam int TimeoutCycles = RowCount * (ProgLen + 4) * (5 + `ALU_LATENCY + 4);

    localparam logic [31:0] ResultAddr = 32'h0000_0040;
    localparam logic [31:0] PoisonAddr = 32'h0000_0044;
    localparam logic [31:0] LoadAddr = 32'h0000_0050;
    localparam logic [31:0] StoreBase = 32'h0000_0060;
    localparam logic [31:0] HandlerAddr = 32'h0000_0030;
    localparam logic [4:0] ThrowVector = 5'd7;
    localparam logic [11:0] Marker = 12'h5a5;

    typedef enum int {tAlu, tLoad, tStore, tBranch, tThrow, tZero} testType;

    typedef struct {
        testType     kindOfTest;
        aluOp        op;
        operandKind  kind;
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] imm;
        logic [31:0] expAddr;
        logic [31:0] expData;
    } testRow;

    logic        clk;
    logic        reset_n;
    logic        halt;
    logic [31:0] iData;
    logic [31:0] dRdata;
    logic [31:0] iAddr;
    logic [31:0] dAddr;
    logic [31:0] dWdata;
    logic        dStrobe;
    logic        dWrite;
    logic        timedOut;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    testRow      tests [RowCount];
    int          rowCount;
    logic [31:0] lcgState;

    cpuTop dut_i (
        .clk(clk), .reset_n(reset_n), .halt(halt), .iData(iData), .dRdata(dRdata),
        .iAddr(iAddr), .dAddr(dAddr), .dWdata(dWdata), .dStrobe(dStrobe), .dWrite(dWrite)
    );

    tbChecker #(.TimeoutCycles(TimeoutCycles)) checker_i (
        .clk(clk), .dStrobe(dStrobe), .dWrite(dWrite), .dAddr(dAddr), .dWdata(dWdata),
        .timedOut(timedOut)
    );

    // Both memories answer in the same cycle
    // Read data is only valid while a read is strobed
    assign iData  = imem[iAddr[7:0]];
    assign dRdata = (dStrobe && !dWrite) ? dmem[dAddr[7:0]] : 32'h0;

    always @(posedge clk) begin
        if (dStrobe && dWrite) begin
            dmem[dAddr[7:0]] <= dWdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (timedOut) begin
            $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [11:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[27:16];
    endfunction

    function automatic logic [31:0] sx(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] fillWord(input logic [7:0] addr);
        return {addr, ~addr, addr ^ 8'h5c, addr + 8'hc3};
    endfunction

    function automatic logic [31:0] encode(input operandKind kind, input logic st,
                                           input logic dr, input logic [3:0] z,
                                           input logic [3:0] x, input logic [3:0] y,
                                           input aluOp op, input logic [11:0] imm);
        return {kind, st, dr, z, x, y, op, imm};
    endfunction

    // Immediate add from r0 into rz
    function automatic logic [31:0] loadImm(input logic [3:0] z, input logic [11:0] v);
        return encode(kindXYI, 1'b0, 1'b0, z, 4'd0, 4'd0, opAdd, v);
    endfunction

    function automatic logic [31:0] storeReg(input logic [3:0] z, input logic [31:0] addr);
        return encode(kindXYI, 1'b1, 1'b1, z, 4'd0, 4'd0, opAdd, addr[11:0]);
    endfunction

    function automatic logic [31:0] jumpTo(input logic [31:0] addr);
        return encode(kindXYI, 1'b0, 1'b0, 4'd15, 4'd0, 4'd0, opAdd, addr[11:0]);
    endfunction

    function automatic logic [31:0] aluModel(input aluOp op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        r;
        sa = a;
        sb = b;
        case (op)
            opOr:    r = a | b;
            opAnd:   r = a & b;
            opAdd:   r = a + b;
            opMul:   r = a * b;
            opShl:   r = a << b[4:0];
            opLt:    r = (sa < sb) ? 32'hffff_ffff : 32'h0;
            opEq:    r = (a == b) ? 32'hffff_ffff : 32'h0;
            opGe:    r = (sa >= sb) ? 32'hffff_ffff : 32'h0;
            opAndn:  r = a & ~b;
            opXor:   r = a ^ b;
            opSub:   r = a - b;
            opXnor:  r = ~(a ^ b);
            opShr:   r = a >> b[4:0];
            opNe:    r = (a != b) ? 32'hffff_ffff : 32'h0;
            opSar:   r = sa >>> b[4:0];
            default: r = 32'h0;
        endcase
        return r;
    endfunction

    task automatic addRow(input testType t, input aluOp op, input operandKind kind,
                          input logic [11:0] a, input logic [11:0] b, input logic [11:0] imm);
        testRow row;
        row.kindOfTest = t;
        row.op = op;
        row.kind = kind;
        row.a = a;
        row.b = b;
        row.imm = imm;
        // Keep shift amounts on the B input below 32
        if (t == tAlu && (op == opShl || op == opShr || op == opSar)) begin
            case (kind)
                kindXYI: row.b = b & 12'h01f;
                kindXIY: row.imm = imm & 12'h01f;
                default: row.a = a & 12'h01f;
            endcase
        end
        if (t == tStore) begin
            row.b = b & 12'h00f;
        end
        row.expAddr = ResultAddr;
        case (t)
            tAlu: begin
                case (kind)
                    kindXYI: row.expData = aluModel(op, sx(row.a), sx(row.b)) + sx(row.imm);
                    kindXIY: row.expData = aluModel(op, sx(row.a), sx(row.imm)) + sx(row.b);
                    default: row.expData = aluModel(op, sx(row.imm), sx(row.a)) + sx(row.b);
                endcase
            end
            tLoad:   row.expData = fillWord(LoadAddr[7:0]);
            tStore: begin
                row.expAddr = StoreBase + sx(row.b);
                row.expData = sx(row.a);
            end
            tBranch: row.expData = sx(row.a);
            tThrow:  row.expData = sx(Marker);
            default: row.expData = 32'h0;
        endcase
        tests[rowCount] = row;
        rowCount++;
    endtask

    task automatic loadProgram(input testRow r);
        int pc;
        pc = `RESET_VECTOR;
        imem[pc]     = loadImm(4'd1, r.a);
        imem[pc + 1] = loadImm(4'd2, r.b);
        case (r.kindOfTest)
            tAlu: begin
                imem[pc + 2] = encode(r.kind, 1'b0, 1'b0, 4'd3, 4'd1, 4'd2, r.op, r.imm);
                imem[pc + 3] = storeReg(4'd3, ResultAddr);
                imem[pc + 4] = jumpTo(pc + 4);
            end
            tLoad: begin
                imem[pc + 2] = encode(kindXYI, 1'b0, 1'b1, 4'd3, 4'd0, 4'd0, opAdd,
                                      LoadAddr[11:0]);
                imem[pc + 3] = storeReg(4'd3, ResultAddr);
                imem[pc + 4] = jumpTo(pc + 4);
            end
            tStore: begin
                imem[pc + 2] = encode(kindXYI, 1'b1, 1'b1, 4'd1, 4'd2, 4'd0, opAdd,
                                      StoreBase[11:0]);
                imem[pc + 3] = jumpTo(pc + 3);
            end
            tBranch: begin
                imem[pc + 1] = jumpTo(pc + 4);
                imem[pc + 2] = storeReg(4'd1, PoisonAddr);
                imem[pc + 3] = storeReg(4'd1, PoisonAddr);
                imem[pc + 4] = storeReg(4'd1, ResultAddr);
                imem[pc + 5] = jumpTo(pc + 5);
            end
            tThrow: begin
                imem[pc + 1] = encode(kindThrow, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, opOr,
                                      {7'd0, ThrowVector});
                imem[pc + 2] = storeReg(4'd1, PoisonAddr);
                imem[pc + 3] = jumpTo(pc + 3);
                imem[HandlerAddr]     = loadImm(4'd3, Marker);
                imem[HandlerAddr + 1] = storeReg(4'd3, ResultAddr);
                imem[HandlerAddr + 2] = jumpTo(HandlerAddr + 2);
                dmem[(`VECTOR_BASE | ThrowVector) & 8'hff] <= HandlerAddr;
            end
            default: begin
                // Write to r0 must not stick
                imem[pc]     = loadImm(4'd0, r.a);
                imem[pc + 1] = storeReg(4'd0, ResultAddr);
                imem[pc + 2] = jumpTo(pc + 2);
            end
        endcase
    endtask

    function automatic string testName(input testRow r);
        case (r.kindOfTest)
            tAlu:    return $sformatf("%s %s", r.op.name(), r.kind.name());
            tLoad:   return "load";
            tStore:  return "store";
            tBranch: return "branch";
            tThrow:  return "throw";
            default: return "r0 write";
        endcase
    endfunction

    initial begin
        reset_n = 1'b0;
        halt = 1'b1;
        lcgState = 32'h8d55;
        rowCount = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = jumpTo(i);
            dmem[i] <= fillWord(i[7:0]);
        end

        for (int i = 0; i < 16; i++) begin
            if (i != 4) begin
                addRow(tAlu, aluOp'(i), kindXYI, lcgNext(), lcgNext(), 12'h000);
            end
        end
        addRow(tAlu, opSub, kindXIY, lcgNext(), lcgNext(), lcgNext());
        addRow(tAlu, opSub, kindIXY, lcgNext(), lcgNext(), lcgNext());
        addRow(tAlu, opShl, kindXIY, lcgNext(), lcgNext(), lcgNext());
        addRow(tAlu, opShl, kindIXY, lcgNext(), lcgNext(), lcgNext());
        addRow(tLoad, opAdd, kindXYI, lcgNext(), lcgNext(), 12'h000);
        addRow(tStore, opAdd, kindXYI, lcgNext(), lcgNext(), 12'h000);
        addRow(tBranch, opAdd, kindXYI, lcgNext(), lcgNext(), 12'h000);
        addRow(tThrow, opAdd, kindXYI, lcgNext(), lcgNext(), 12'h000);
        addRow(tZero, opAdd, kindXYI, lcgNext(), lcgNext(), 12'h000);

        repeat (10) @(negedge clk);
        reset_n = 1'b1;

        for (int n = 0; n < rowCount; n++) begin
            while (dut_i.control_i.state != sIdle) @(negedge clk);
            loadProgram(tests[n]);
            checker_i.beginTest(n, testName(tests[n]), PoisonAddr);
            if (tests[n].kindOfTest == tThrow) begin
                // Throw sits one word after the reset vector
                checker_i.expectStore(`TRAP_SLOT, `RESET_VECTOR + 32'd1);
            end
            checker_i.expectStore(tests[n].expAddr, tests[n].expData);
            @(negedge clk);
            halt = 1'b0;
            while (checker_i.doneCount != n + 1) @(negedge clk);
            halt = 1'b1;
        end

        $display("Tests run %0d, passed %0d, failed %0d",
                 rowCount, checker_i.passCount, checker_i.failCount);
        if (checker_i.failCount == 0 && checker_i.passCount == rowCount) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
cpuPkg.sv
regFile.sv
insnDecode.sv
stepTimer.sv
execUnit.sv
coreControl.sv
cpuTop.sv
tbChecker.sv
tbTop.sv
